// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing
TOP        = kbd_tb
FILELIST   = vlog.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = No errors

SOURCES = $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: host_port.sv
`timescale 1ns/1ps

module host_port import kbd_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  key_event_t ev,
	input  logic       ev_valid,
	output logic       ev_ready,
	input  logic       pb6,
	input  logic       pb7,
	output pc_code_t   pa,
	output logic       irq1
);

	host_state_e state_q;
	host_state_e state_d;
	pc_code_t    pa_d;
	logic        irq_d;

	// only an idle port with no reset request takes events
	assign ev_ready = (state_q == st_idle) && pb6;

	always_comb begin
		state_d = state_q;
		pa_d    = pa;
		irq_d   = irq1;

		if (!pb6) begin
			// reset request wins in every state, pa is left alone
			state_d = st_kb_reset;
			irq_d   = 1'b0;
		end else begin
			case (state_q)
				st_idle: begin
					if (ev_valid && ev_ready) begin
						state_d = st_hold;
						pa_d    = pc_code_t'(ev);
						irq_d   = 1'b1;
					end
				end
				st_hold: begin
					if (pb7) begin // host acknowledge
						state_d = st_wait_clr;
						irq_d   = 1'b0;
					end
				end
				st_wait_clr: begin
					if (!pb7) begin
						state_d = st_idle;
						pa_d    = '0;
					end
				end
				st_kb_reset: begin
					state_d = st_kb_release; // pb6 is high again here
				end
				st_kb_release: begin
					// keyboard answers once the irq line is free
					if (!pb7) begin
						state_d = st_hold;
						pa_d    = SELF_TEST_OK;
						irq_d   = 1'b1;
					end
				end
				default: begin
					state_d = st_idle;
					pa_d    = '0;
					irq_d   = 1'b0;
				end
			endcase
		end
	end

	// st_wait_clr after reset, so a pb7 still high is waited out
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= st_wait_clr;
			pa      <= '0;
			irq1    <= 1'b0;
		end else begin
			state_q <= state_d;
			pa      <= pa_d;
			irq1    <= irq_d;
		end
	end

	a_irq_in_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		irq1 |-> (state_q == st_hold)
	) else $error("irq1 high outside st_hold");

endmodule

// File: kbd_pkg.sv
package kbd_pkg;

	// byte as sent by the keyboard, scan code set 2
	typedef logic [7:0] scan_code_t;

	// byte as read by the PC on port A, scan code set 1
	typedef logic [7:0] pc_code_t;

	// bit position inside one PS/2 frame
	typedef logic [3:0] frame_count_t;

	// start, 8 data, parity, stop
	localparam int FRAME_BITS = 11;

	// flops on each PS/2 line before use
	localparam int SYNC_STAGES = 2;

	// set-2 break prefix, precedes the code of a released key
	localparam scan_code_t BREAK_PREFIX = 8'hf0;

	// answer to a keyboard reset request
	localparam pc_code_t SELF_TEST_OK = 8'haa;

	// one translated key event, laid out exactly as the pa byte
	typedef struct packed {
		logic       released; // bit 7 of pa
		logic [6:0] code;     // low bits of the set-1 code
	} key_event_t;

	// host side handshake states
	typedef enum logic [2:0] {
		st_idle,       // ready for the next event
		st_hold,       // irq1 up, pa valid
		st_wait_clr,   // pb7 seen high, wait for it to drop
		st_kb_reset,   // pb6 held low by the host
		st_kb_release  // pb6 back high, wait for pb7 low
	} host_state_e;

endpackage

// File: kbd_port.sv
`timescale 1ns/1ps

module kbd_port import kbd_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     ps2_clk,
	input  logic     ps2_data,
	input  logic     pb6,   // low requests keyboard reset
	input  logic     pb7,   // high acknowledges irq1
	output pc_code_t pa,
	output logic     irq1
);

	scan_code_t rx_code;
	logic       rx_valid;
	key_event_t ev;
	logic       ev_valid;
	logic       ev_ready;

	// PS/2 frame in, raw set-2 byte out
	ps2_rx rx_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.rx_code  (rx_code),
		.rx_valid (rx_valid)
	);

	// translation and break folding, one event deep
	scan_xlat xlat_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.rx_code  (rx_code),
		.rx_valid (rx_valid),
		.ev       (ev),
		.ev_valid (ev_valid),
		.ev_ready (ev_ready)
	);

	host_port host_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.ev       (ev),
		.ev_valid (ev_valid),
		.ev_ready (ev_ready),
		.pb6      (pb6),
		.pb7      (pb7),
		.pa       (pa),
		.irq1     (irq1)
	);

endmodule

// File: kbd_tb.sv
`timescale 1ns/1ps

module kbd_tb import kbd_pkg::*; ();

	localparam int CLK_NS       = 8;
	localparam int HALF         = 6;   // PS/2 half period in clk cycles
	localparam int GAP          = 12;  // idle cycles after each frame
	localparam int FRAME_CYCLES = FRAME_BITS * 2 * HALF + GAP;
	localparam int NUM_FRAMES   = 48;  // 40 make, 5 break, 3 back-pressure
	localparam int IRQ_WAIT     = 100;
	localparam int WATCHDOG_NS  = (NUM_FRAMES * FRAME_CYCLES + 2 * FRAME_CYCLES + 2000) * CLK_NS;

	localparam logic [7:0] BREAK_CODE  = 8'hf0; // set-2 release prefix
	localparam logic [7:0] RESET_REPLY = 8'haa; // keyboard self-test passed

	// set-2 make code to set-1 code, indexed by the set-2 code 00-7F
	localparam logic [7:0] SET1_TBL [0:127] = '{
		8'hff, 8'h43, 8'h41, 8'h3f, 8'h3d, 8'h3b, 8'h3c, 8'h58,
		8'h64, 8'h44, 8'h42, 8'h40, 8'h3e, 8'h0f, 8'h29, 8'h59,
		8'h65, 8'h38, 8'h2a, 8'h70, 8'h1d, 8'h10, 8'h02, 8'h5a,
		8'h66, 8'h71, 8'h2c, 8'h1f, 8'h1e, 8'h11, 8'h03, 8'h5b,
		8'h67, 8'h2e, 8'h2d, 8'h20, 8'h12, 8'h05, 8'h04, 8'h5c,
		8'h68, 8'h39, 8'h2f, 8'h21, 8'h14, 8'h13, 8'h06, 8'h5d,
		8'h69, 8'h31, 8'h30, 8'h23, 8'h22, 8'h15, 8'h07, 8'h5e,
		8'h6a, 8'h72, 8'h32, 8'h24, 8'h16, 8'h08, 8'h09, 8'h5f,
		8'h6b, 8'h33, 8'h25, 8'h17, 8'h18, 8'h0b, 8'h0a, 8'h60,
		8'h6c, 8'h34, 8'h35, 8'h26, 8'h27, 8'h19, 8'h0c, 8'h61,
		8'h6d, 8'h73, 8'h28, 8'h74, 8'h1a, 8'h0d, 8'h62, 8'h6e,
		8'h3a, 8'h36, 8'h1c, 8'h1b, 8'h75, 8'h2b, 8'h63, 8'h76,
		8'h55, 8'h56, 8'h77, 8'h78, 8'h79, 8'h7a, 8'h0e, 8'h7b,
		8'h7c, 8'h4f, 8'h7d, 8'h4b, 8'h47, 8'h7e, 8'h7f, 8'h6f,
		8'h52, 8'h53, 8'h50, 8'h4c, 8'h4d, 8'h48, 8'h01, 8'h45,
		8'h57, 8'h4e, 8'h51, 8'h4a, 8'h37, 8'h49, 8'h46, 8'h54
	};

	logic        clk;
	logic        rst_n;
	logic        ps2_clk;
	logic        ps2_data;
	logic        pb6;
	logic        pb7;
	logic [7:0]  pa;
	logic        irq1;

	logic [31:0] lfsr_q = 32'd90554;
	logic [7:0]  want_pa;         // expected pa for the next irq1
	int          want_cnt = 0;    // expectations issued by the stimulus
	int          seen_cnt = 0;    // irq1 rises compared so far
	int          errors = 0;
	int          checks = 0;
	int          chk_errors = 0;
	int          chk_count = 0;
	logic        irq_prev;

	kbd_port dut_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.pb6      (pb6),
		.pb7      (pb7),
		.pa       (pa),
		.irq1     (irq1)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
	endfunction

	// one lfsr step per bit taken
	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			b = {b[6:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
		return b;
	endfunction

	function automatic logic [7:0] rand_make();
		logic [7:0] c;
		c = rand_byte();
		while (c == BREAK_CODE)
			c = rand_byte();
		return c;
	endfunction

	// set-2 to set-1 rule, 83 and 84 are the two extras above 7F
	function automatic logic [7:0] ref_xlat(input logic [7:0] code);
		if (code < 8'h80)
			return SET1_TBL[code[6:0]];
		else if (code == 8'h83)
			return 8'h41;
		else if (code == 8'h84)
			return 8'h54;
		return code;
	endfunction

	// set-1 byte has bit 7 clear, so only a break can set it
	function automatic logic [7:0] rand_make_top_clear();
		logic [7:0] c;
		c = rand_make();
		while (ref_xlat(c) >= 8'h80)
			c = rand_make();
		return c;
	endfunction

	function automatic logic [7:0] expect_pa(input logic [7:0] code, input bit released);
		logic [7:0] x;
		x = ref_xlat(code);
		if (released)
			x[7] = 1'b1; // break code sets the top bit
		return x;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic print_mismatch(input string name, input logic [7:0] got,
			input logic [7:0] exp);
		$display("FAILED at %0t ns: %s = %02h, expected %02h", $time, name, got, exp);
	endtask

	// start, 8 data lsb first, odd parity, stop
	task automatic send_frame(input logic [7:0] code);
		logic [10:0] bits;
		bits = {1'b1, ~^code, code, 1'b0};
		for (int i = 0; i < FRAME_BITS; i++) begin
			ps2_data = bits[i];
			wait_cycles(HALF);
			ps2_clk = 1'b0;   // receiver samples here
			wait_cycles(HALF);
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1;
		wait_cycles(GAP);
	endtask

	task automatic expect_event(input logic [7:0] value);
		want_pa  = value;
		want_cnt = want_cnt + 1;
	endtask

	task automatic wait_irq(input string what);
		int n;
		n = 0;
		while (irq1 !== 1'b1 && n < IRQ_WAIT) begin
			wait_cycles(1);
			n++;
		end
		if (irq1 !== 1'b1) begin
			$display("timeout at %0t ns: irq1 did not rise for the %s", $time, what);
			errors++;
		end else begin
			wait_cycles(1); // checker samples on this edge
		end
	endtask

	task automatic ack_irq(input bit check_clear);
		pb7 = 1'b1;
		wait_cycles(2);
		pb7 = 1'b0;
		wait_cycles(2);
		if (check_clear) begin
			checks += 2;
			if (irq1 !== 1'b0) begin
				print_mismatch("irq1", {7'b0, irq1}, 8'h00);
				errors++;
			end
			if (pa !== 8'h00) begin
				print_mismatch("pa", pa, 8'h00);
				errors++;
			end
		end
	endtask

	task automatic close_test(input int num, input string name, input int errs_before);
		if (errors + chk_errors == errs_before)
			$display("test %0d %s: pass", num, name);
		else
			$display("test %0d %s: fail, %0d errors", num, name,
				errors + chk_errors - errs_before);
	endtask

	// compares pa on every rise of irq1
	always @(posedge clk) begin
		if (rst_n !== 1'b1) begin
			irq_prev <= 1'b0;
		end else begin
			if (irq1 === 1'b1 && irq_prev === 1'b0) begin
				if (seen_cnt >= want_cnt) begin
					$display("irq1 rose at %0t ns with no event pending, pa = %02h", $time, pa);
					chk_errors = chk_errors + 1;
				end else begin
					chk_count = chk_count + 1;
					if (pa !== want_pa) begin
						print_mismatch("pa", pa, want_pa);
						chk_errors = chk_errors + 1;
					end
				end
				seen_cnt = want_cnt;
			end
			irq_prev <= irq1;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired at %0t ns, the run is stuck", $time);
		$display("Errors found");
		$finish;
	end

	initial begin
		logic [7:0] code;
		logic [7:0] code_a;
		logic [7:0] code_b;
		logic [7:0] code_c;
		int         mark;

		rst_n    = 1'b0;
		ps2_clk  = 1'b1;
		ps2_data = 1'b1;
		pb6      = 1'b1;
		pb7      = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;

		mark = 0;
		wait_cycles(2);
		checks += 2;
		if (pa !== 8'h00) begin
			print_mismatch("pa", pa, 8'h00);
			errors++;
		end
		if (irq1 !== 1'b0) begin
			print_mismatch("irq1", {7'b0, irq1}, 8'h00);
			errors++;
		end
		close_test(1, "reset values", mark);

		mark = errors + chk_errors;
		for (int i = 0; i < 40; i++) begin
			code = rand_make();
			expect_event(expect_pa(code, 1'b0));
			send_frame(code);
			wait_irq("make code");
			ack_irq(1'b1);
		end
		close_test(2, "random make codes", mark);

		mark = errors + chk_errors;
		code = rand_make_top_clear();
		expect_event(expect_pa(code, 1'b1));
		send_frame(BREAK_CODE);
		send_frame(code);
		wait_irq("break code");
		ack_irq(1'b1);
		code = rand_make_top_clear();
		expect_event(expect_pa(code, 1'b1));
		send_frame(BREAK_CODE); // prefix twice
		send_frame(BREAK_CODE);
		send_frame(code);
		wait_irq("break code after double prefix");
		ack_irq(1'b1);
		close_test(3, "break prefix", mark);

		mark = errors + chk_errors;
		code_a = rand_make();
		code_b = rand_make();
		code_c = rand_make();
		expect_event(expect_pa(code_a, 1'b0));
		send_frame(code_a);
		wait_irq("first held code");
		expect_event(expect_pa(code_b, 1'b0));
		send_frame(code_b);  // waits in the translator
		send_frame(code_c);  // no room, lost
		checks += 2;
		if (irq1 !== 1'b1) begin
			print_mismatch("irq1", {7'b0, irq1}, 8'h01);
			errors++;
		end
		if (pa !== expect_pa(code_a, 1'b0)) begin
			print_mismatch("pa", pa, expect_pa(code_a, 1'b0));
			errors++;
		end
		ack_irq(1'b0);
		wait_irq("second held code");
		ack_irq(1'b1);
		wait_cycles(2 * FRAME_CYCLES);
		checks++;
		if (irq1 !== 1'b0) begin
			$display("third code showed up on pa at %0t ns although it had no room", $time);
			errors++;
		end
		close_test(4, "back-pressure", mark);

		mark = errors + chk_errors;
		expect_event(RESET_REPLY);
		pb6 = 1'b0;
		wait_cycles(20);
		pb6 = 1'b1;  // pb7 is already low
		wait_irq("self-test byte");
		ack_irq(1'b1);
		close_test(5, "keyboard reset", mark);

		if (seen_cnt != want_cnt) begin
			$display("%0d expected events never reached pa", want_cnt - seen_cnt);
			errors++;
		end

		$display("%0d checks, %0d errors", checks + chk_count, errors + chk_errors);
		if (errors + chk_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: ps2_rx.sv
`timescale 1ns/1ps

module ps2_rx import kbd_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	output scan_code_t rx_code,
	output logic       rx_valid
);

	logic [SYNC_STAGES-1:0] clk_sync;
	logic [SYNC_STAGES-1:0] data_sync;
	logic                   clk_prev;  // last synchronized ps2_clk
	logic                   clk_s;
	logic                   data_s;
	logic                   clk_fall;
	logic                   data_pos;  // current position holds a data bit
	logic                   frame_end;
	frame_count_t           bit_cnt;
	scan_code_t             shift_q;

	assign clk_s  = clk_sync[SYNC_STAGES-1];
	assign data_s = data_sync[SYNC_STAGES-1];

	// both lines idle high, so the chain resets to ones
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clk_sync  <= '1;
			data_sync <= '1;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[SYNC_STAGES-2:0], ps2_clk};
			data_sync <= {data_sync[SYNC_STAGES-2:0], ps2_data};
			clk_prev  <= clk_s;
		end
	end

	// keyboard changes data on the rising edge, we sample on the falling one
	assign clk_fall = clk_prev & ~clk_s;

	assign data_pos  = (bit_cnt >= frame_count_t'(1)) && (bit_cnt <= frame_count_t'(8));
	assign frame_end = (bit_cnt == frame_count_t'(FRAME_BITS - 1));

	// position counter, start bit is position 0
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= clk_fall & frame_end; // one pulse per stop bit
			if (clk_fall) begin
				if (frame_end)
					bit_cnt <= '0; // wrap after the stop bit
				else
					bit_cnt <= bit_cnt + frame_count_t'(1);
			end
		end
	end

	// data arrives lsb first, so shift in from the top
	always_ff @(posedge clk) begin
		if (clk_fall && data_pos)
			shift_q <= {data_s, shift_q[7:1]};
	end

	// parity and stop are only counted
	assign rx_code = shift_q;

	a_rx_valid_single: assert property (
		@(posedge clk) disable iff (!rst_n)
		rx_valid |=> !rx_valid
	) else $error("rx_valid held for more than one cycle");

endmodule

// File: scan_xlat.sv
`timescale 1ns/1ps

module scan_xlat import kbd_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  scan_code_t rx_code,
	input  logic       rx_valid,
	output key_event_t ev,
	output logic       ev_valid,
	input  logic       ev_ready
);

	logic [127:0] xlat_row;   // sixteen set-1 bytes, code x0 in the top byte
	pc_code_t     xlat_code;
	logic         is_prefix;
	logic         release_q;  // F0 seen, waiting for its code
	logic         load;

	// set-2 to set-1 translation, one row per upper nibble of 00-7F
	always_comb begin
		case (rx_code[6:4])
			3'h0: xlat_row = 128'hff43413f3d3b3c58644442403e0f2959;
			3'h1: xlat_row = 128'h65382a701d10025a66712c1f1e11035b;
			3'h2: xlat_row = 128'h672e2d201205045c68392f211413065d;
			3'h3: xlat_row = 128'h693130232215075e6a7232241608095f;
			3'h4: xlat_row = 128'h6b332517180b0a606c34352627190c61;
			3'h5: xlat_row = 128'h6d7328741a0d626e3a361c1b752b6376;
			3'h6: xlat_row = 128'h55567778797a0e7b7c4f7d4b477e7f6f;
			default: xlat_row = 128'h5253504c4d480145574e514a37494654;
		endcase

		if (!rx_code[7])
			xlat_code = xlat_row[{~rx_code[3:0], 3'b000} +: 8];
		else if (rx_code == 8'h83)
			xlat_code = 8'h41; // F7
		else if (rx_code == 8'h84)
			xlat_code = 8'h54; // alt+sysrq
		else
			xlat_code = rx_code; // rest of 80-FF goes through as is
	end

	assign is_prefix = (rx_code == BREAK_PREFIX);

	// take a code when the slot is empty or drains this same cycle
	assign load = rx_valid && !is_prefix && (!ev_valid || ev_ready);

	// F0 arms the flag, the next real code clears it
	// whether or not that code finds room
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			release_q <= 1'b0;
		else if (rx_valid)
			release_q <= is_prefix;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ev_valid <= 1'b0;
		else if (load)
			ev_valid <= 1'b1;
		else if (ev_ready)
			ev_valid <= 1'b0;
	end

	// a make code keeps its own bit 7, a break code forces it
	always_ff @(posedge clk) begin
		if (load) begin
			ev.released <= release_q | xlat_code[7];
			ev.code     <= xlat_code[6:0];
		end
	end

	a_ev_stable: assert property (
		@(posedge clk) disable iff (!rst_n)
		(ev_valid && !ev_ready) |=> (ev_valid && $stable(ev))
	) else $error("event changed while waiting for the host");

endmodule

// File: vlog.f
kbd_pkg.sv
ps2_rx.sv
scan_xlat.sv
host_port.sv
kbd_port.sv
kbd_tb.sv
